// ==== lc3b_defines.svh ====
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// ----------------------------------------------------------------------
// cache geometry
// ----------------------------------------------------------------------

// eight direct-mapped lines of sixteen bytes each.
`define CACHE_LINES   8
`define LINE_BITS     128
`define WORD_BITS     16

// tag, index and offset together fill one WORD_BITS address.
`define TAG_BITS      9
`define INDEX_BITS    3
`define OFFSET_BITS   4

// memory model delay in cycles from request to response.
`define PMEM_LATENCY  5

`endif

// ==== lc3b_types.sv ====
`default_nettype none

`include "lc3b_defines.svh"

package lc3b_types;

	typedef logic [`WORD_BITS-1:0] lc3b_word;
	typedef logic [`LINE_BITS-1:0] lc3b_line;
	typedef logic [`LINE_BITS/8-1:0] lc3b_mask;

	typedef struct packed {
		logic [`TAG_BITS-1:0]    tag;
		logic [`INDEX_BITS-1:0]  index;
		logic [`OFFSET_BITS-1:0] offset;
	} cache_addr_fields_t;

	// the same address word seen raw on the ports or split for lookup.
	typedef union packed {
		lc3b_word           word;
		cache_addr_fields_t fields;
	} lc3b_cache_addr;

	typedef struct packed {
		logic       read;
		logic       write;
		lc3b_word   address;
		lc3b_word   wdata;
		logic [1:0] byte_enable;
	} cache_req_t;

	typedef struct packed {
		logic     read;
		logic     write;
		lc3b_word address;
		lc3b_line wdata;
	} pmem_req_t;

endpackage

`default_nettype wire

// ==== sel_bytes.sv ====
`default_nettype none
`timescale 1ns/10ps

module sel_bytes import lc3b_types::*; (
	input  lc3b_word   mem_address,
	input  logic [1:0] mem_byte_enable,
	output lc3b_mask   sel_mask
);

	logic [2:0] slot;
	logic       odd;
	logic [1:0] lanes;

	// bits 3 to 1 pick the word slot, bit 0 marks an odd byte address.
	assign slot = mem_address[3:1];
	assign odd  = mem_address[0];

	// ----------------------------------------------------------------------
	// lane pair inside the word slot
	// ----------------------------------------------------------------------

	// an odd address stores its byte through the high lane.
	// Both lanes are only set there when both enables are high.
	always_comb begin
		if (!odd) begin
			lanes = mem_byte_enable;
		end
		else if (mem_byte_enable == 2'b11) begin
			lanes = 2'b11;
		end
		else begin
			lanes = 2'b10;
		end
	end

	// ----------------------------------------------------------------------
	// place the pair at its slot in the line mask
	// ----------------------------------------------------------------------

	always_comb begin
		sel_mask = '0;
		for (int i = 0; i < 8; i++) begin
			if (slot == 3'(i)) begin
				sel_mask[2*i +: 2] = lanes;
			end
		end
	end

endmodule : sel_bytes

`default_nettype wire

// ==== cache_datapath.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module cache_datapath import lc3b_types::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  cache_req_t req,
	input  logic       load_line,
	input  logic       write_hit,
	input  lc3b_line   pmem_rdata,
	output logic       hit,
	output logic       dirty,
	output lc3b_word   mem_rdata,
	output lc3b_word   pmem_addr,
	output lc3b_line   pmem_wline,
	input  logic       writeback_sel
);

	lc3b_line                data_q [`CACHE_LINES];
	logic [`TAG_BITS-1:0]    tag_q [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid_q;
	logic [`CACHE_LINES-1:0] dirty_q;

	lc3b_cache_addr          cpu_addr;
	lc3b_cache_addr          line_addr;
	logic [`INDEX_BITS-1:0]  idx;
	lc3b_line                cur_line;
	lc3b_line                wr_line;
	lc3b_line                merged;
	lc3b_mask                lane_mask;

	assign cpu_addr.word = req.address;
	assign idx           = cpu_addr.fields.index;
	assign cur_line      = data_q[idx];

	assign hit   = valid_q[idx] && (tag_q[idx] == cpu_addr.fields.tag);
	assign dirty = dirty_q[idx];

	assign mem_rdata = cur_line[{cpu_addr.fields.offset[`OFFSET_BITS-1:1], 4'b0000} +: `WORD_BITS];

	// ----------------------------------------------------------------------
	// write merge
	// ----------------------------------------------------------------------

	sel_bytes sel_bytes_i (
		.mem_address     (req.address),
		.mem_byte_enable (req.byte_enable),
		.sel_mask        (lane_mask)
	);

	// the write word sits in every slot, the mask decides which bytes land.
	assign wr_line = {(`LINE_BITS/`WORD_BITS){req.wdata}};

	always_comb begin
		for (int b = 0; b < `LINE_BITS/8; b++) begin
			merged[8*b +: 8] = lane_mask[b] ? wr_line[8*b +: 8] : cur_line[8*b +: 8];
		end
	end

	// ----------------------------------------------------------------------
	// memory side address and line
	// ----------------------------------------------------------------------

	always_comb begin
		line_addr.fields.tag    = writeback_sel ? tag_q[idx] : cpu_addr.fields.tag;
		line_addr.fields.index  = idx;
		line_addr.fields.offset = '0;
	end

	assign pmem_addr  = line_addr.word;
	assign pmem_wline = cur_line;

	always_ff @(posedge clk) begin
		if (load_line) begin
			data_q[idx] <= pmem_rdata;
			tag_q[idx]  <= cpu_addr.fields.tag;
		end
		else if (write_hit) begin
			data_q[idx] <= merged;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (load_line) begin
			valid_q[idx] <= 1'b1;
			dirty_q[idx] <= 1'b0;
		end
		else if (write_hit) begin
			dirty_q[idx] <= 1'b1;
		end
	end

	a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_line && write_hit));

endmodule : cache_datapath

`default_nettype wire

// ==== cache_control.sv ====
`default_nettype none
`timescale 1ns/10ps

module cache_control import lc3b_types::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  cache_req_t req,
	input  logic       hit,
	input  logic       dirty,
	input  logic       pmem_resp,
	output logic       mem_resp,
	output logic       load_line,
	output logic       write_hit,
	output logic       writeback_sel,
	output logic       pmem_read,
	output logic       pmem_write
);

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		FILL
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   req_valid;
	logic   lookup;
	logic   resp_d;

	assign req_valid = req.read || req.write;

	// the cycle that carries mem_resp still shows the finished request.
	assign lookup = (state_q == IDLE) && req_valid && !mem_resp;

	// ----------------------------------------------------------------------
	// next state and strobes
	// ----------------------------------------------------------------------

	always_comb begin
		state_d       = state_q;
		resp_d        = 1'b0;
		load_line     = 1'b0;
		write_hit     = 1'b0;
		writeback_sel = 1'b0;
		pmem_read     = 1'b0;
		pmem_write    = 1'b0;
		case (state_q)
			IDLE: begin
				if (lookup) begin
					if (hit) begin
						resp_d    = 1'b1;
						write_hit = req.write;
					end
					else if (dirty) begin
						state_d = WRITEBACK;
					end
					else begin
						state_d = FILL;
					end
				end
			end
			WRITEBACK: begin
				writeback_sel = 1'b1;
				pmem_write    = 1'b1;
				if (pmem_resp) begin
					state_d = FILL;
				end
			end
			FILL: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					load_line = 1'b1;
					state_d   = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= IDLE;
			mem_resp <= 1'b0;
		end
		else begin
			state_q  <= state_d;
			mem_resp <= resp_d;
		end
	end

	a_pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write));

	a_resp_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_resp) |-> req_valid);

	a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp |=> !mem_resp);

endmodule : cache_control

`default_nettype wire

// ==== lc3b_cache.sv ====
`default_nettype none
`timescale 1ns/10ps

module lc3b_cache import lc3b_types::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  cache_req_t req,
	output logic       mem_resp,
	output lc3b_word   mem_rdata,
	output pmem_req_t  pmem,
	input  logic       pmem_resp,
	input  lc3b_line   pmem_rdata
);

	logic     hit;
	logic     dirty;
	logic     load_line;
	logic     write_hit;
	logic     writeback_sel;
	logic     pmem_read;
	logic     pmem_write;
	lc3b_word pmem_addr;
	lc3b_line pmem_wline;

	cache_control control_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.hit           (hit),
		.dirty         (dirty),
		.pmem_resp     (pmem_resp),
		.mem_resp      (mem_resp),
		.load_line     (load_line),
		.write_hit     (write_hit),
		.writeback_sel (writeback_sel),
		.pmem_read     (pmem_read),
		.pmem_write    (pmem_write)
	);

	cache_datapath datapath_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.load_line     (load_line),
		.write_hit     (write_hit),
		.pmem_rdata    (pmem_rdata),
		.hit           (hit),
		.dirty         (dirty),
		.mem_rdata     (mem_rdata),
		.pmem_addr     (pmem_addr),
		.pmem_wline    (pmem_wline),
		.writeback_sel (writeback_sel)
	);

	// memory request levels come from control, address and line from the arrays.
	assign pmem = '{read: pmem_read, write: pmem_write, address: pmem_addr, wdata: pmem_wline};

endmodule : lc3b_cache

`default_nettype wire

// ==== tb_lc3b_cache.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "lc3b_defines.svh"

module tb_lc3b_cache import lc3b_types::*; ();

	localparam int TIMEOUT_CYCLES = 200;

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	cache_req_t req = '0;
	logic       pmem_resp = 1'b0;
	lc3b_line   pmem_rdata = '0;
	logic       mem_resp;
	lc3b_word   mem_rdata;
	pmem_req_t  pmem;

	logic [7:0]              mem [65536];
	logic [7:0]              shadow [65536];
	int                      lat_cnt = 0;
	int                      fill_count = 0;
	int                      wb_count = 0;
	lc3b_word                wb_addr_seen = '0;
	lc3b_line                wb_line_seen = '0;
	logic [`TAG_BITS-1:0]    tb_tag [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] tb_valid;
	int                      pass_count = 0;
	int                      fail_count = 0;
	logic                    aborted = 1'b0;

	always #4 clk = ~clk;

	lc3b_cache dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.mem_resp   (mem_resp),
		.mem_rdata  (mem_rdata),
		.pmem       (pmem),
		.pmem_resp  (pmem_resp),
		.pmem_rdata (pmem_rdata)
	);

	// every byte starts from its own address, high byte folded in.
	function automatic logic [7:0] pattern_byte(input int a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	function automatic lc3b_line shadow_line(input lc3b_word a);
		lc3b_line l;
		for (int b = 0; b < 16; b++) begin
			l[8*b +: 8] = shadow[{a[15:4], b[3:0]}];
		end
		return l;
	endfunction

	task automatic wait_response(output logic timed_out);
		int cycles;
		timed_out = 1'b1;
		cycles = 0;
		while (timed_out && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			timed_out = !mem_resp;
			cycles++;
		end
	endtask

	task automatic wait_writeback(input int start, output logic timed_out);
		int cycles;
		timed_out = 1'b1;
		cycles = 0;
		while (timed_out && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			timed_out = (wb_count == start);
			cycles++;
		end
	endtask

	// ----------------------------------------------------------------------
	// line memory model
	// ----------------------------------------------------------------------

	always @(posedge clk) begin
		pmem_resp <= 1'b0;
		if (!rst_n) begin
			lat_cnt <= 0;
			for (int a = 0; a < 65536; a++) begin
				mem[16'(a)] = pattern_byte(a);
			end
		end
		else if ((pmem.read || pmem.write) && !pmem_resp) begin
			if (lat_cnt < `PMEM_LATENCY - 1) begin
				lat_cnt <= lat_cnt + 1;
			end
			else begin
				lat_cnt   <= 0;
				pmem_resp <= 1'b1;
				for (int b = 0; b < 16; b++) begin
					if (pmem.write) begin
						mem[{pmem.address[15:4], b[3:0]}] = pmem.wdata[8*b +: 8];
					end
					else begin
						pmem_rdata[8*b +: 8] <= mem[{pmem.address[15:4], b[3:0]}];
					end
				end
				if (pmem.write) begin
					wb_count     <= wb_count + 1;
					wb_addr_seen <= pmem.address;
					wb_line_seen <= pmem.wdata;
				end
				else begin
					fill_count <= fill_count + 1;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// golden file driven sequence
	// ----------------------------------------------------------------------

	initial begin : run_golden
		int         fd;
		int         n;
		int         test_no;
		int         fill_start;
		int         wb_start;
		string      line;
		string      wb_tok;
		logic [7:0] op;
		lc3b_word   addr;
		lc3b_word   wdata;
		lc3b_word   exp_data;
		lc3b_word   exp_wb;
		logic [1:0] be;
		logic       miss;
		logic       wb_expected;
		logic       timed_out;
		logic       ok;

		tb_valid = '0;
		test_no = 0;
		for (int a = 0; a < 65536; a++) begin
			shadow[16'(a)] = pattern_byte(a);
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		if (mem_resp || pmem.read || pmem.write) begin
			$display("test 0: response or memory request active after reset");
			fail_count++;
		end
		else begin
			$display("test 0: reset state ok");
			pass_count++;
		end

		fd = $fopen("cache_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open cache_golden.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %h %h %h %h %s", op, addr, be, wdata, exp_data, wb_tok);
			if (n != 6) begin
				$display("malformed line in cache_golden.txt: %s", line);
				aborted = 1'b1;
				break;
			end
			test_no++;
			ok = 1'b1;
			wb_expected = (wb_tok != "none");
			exp_wb = wb_expected ? 16'(wb_tok.atohex()) : 16'h0000;
			miss = !(tb_valid[addr[6:4]] && tb_tag[addr[6:4]] == addr[15:7]);
			fill_start = fill_count;
			wb_start = wb_count;

			@(posedge clk);
			req <= '{read: (op == "R"), write: (op == "W"), address: addr, wdata: wdata,
				byte_enable: be};
			if (wb_expected) begin
				wait_writeback(wb_start, timed_out);
				if (timed_out) begin
					$display("test %0d: timed out waiting for a write-back to memory", test_no);
					aborted = 1'b1;
					break;
				end
			end
			wait_response(timed_out);
			if (timed_out) begin
				$display("test %0d: timed out waiting for mem_resp", test_no);
				aborted = 1'b1;
				break;
			end

			if (op == "R" && mem_rdata !== exp_data) begin
				$display("[ERROR] mem_rdata expected %h got %h", exp_data, mem_rdata);
				ok = 1'b0;
			end
			if (fill_count - fill_start != (miss ? 1 : 0)) begin
				$display("test %0d: expected %0d line fills, saw %0d", test_no,
					miss ? 1 : 0, fill_count - fill_start);
				ok = 1'b0;
			end
			if (wb_count - wb_start != (wb_expected ? 1 : 0)) begin
				$display("test %0d: expected %0d write-backs, saw %0d", test_no,
					wb_expected ? 1 : 0, wb_count - wb_start);
				ok = 1'b0;
			end
			if (wb_expected && wb_addr_seen !== exp_wb) begin
				$display("[ERROR] pmem.address expected %h got %h", exp_wb, wb_addr_seen);
				ok = 1'b0;
			end
			if (wb_expected && wb_line_seen !== shadow_line(exp_wb)) begin
				$display("[ERROR] pmem.wdata expected %h got %h", shadow_line(exp_wb),
					wb_line_seen);
				ok = 1'b0;
			end

			@(posedge clk);
			req <= '0;

			// odd addresses store through the high lane unless both enables are set.
			if (op == "W" && !addr[0] && be[0]) begin
				shadow[addr] = wdata[7:0];
			end
			if (op == "W" && (addr[0] || be[1])) begin
				shadow[addr | 16'h0001] = wdata[15:8];
			end
			if (op == "W" && addr[0] && be == 2'b11) begin
				shadow[addr & 16'hfffe] = wdata[7:0];
			end
			tb_valid[addr[6:4]] = 1'b1;
			tb_tag[addr[6:4]] = addr[15:7];

			$display("test %0d: %c %h be %h %s", test_no, op, addr, be, ok ? "ok" : "FAIL");
			if (ok) begin
				pass_count++;
			end
			else begin
				fail_count++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && !aborted && test_no > 0) begin
			$display("TESTS PASSED");
		end
		else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule : tb_lc3b_cache

`default_nettype wire

// ==== cache_golden.txt ====
# op addr byte_enable wdata expected_rdata expected_writeback
# op is R or W; other columns are hex, the last is an old line address or none
R 0024 3 0000 7f7e none
R 002a 3 0000 7170 none
W 0024 1 abcd 0000 none
R 0024 3 0000 7fcd none
W 0027 1 1234 0000 none
R 0026 3 0000 127c none
W 0029 2 5678 0000 none
R 0028 3 0000 5672 none
W 002c 3 9abc 0000 none
R 002c 3 0000 9abc none
W 002e 2 def0 0000 none
R 002e 3 0000 de74 none
W 0022 0 ffff 0000 none
R 0022 3 0000 7978 none
R 0424 3 0000 7b7a 0020
R 042e 3 0000 7170 none
R 0024 3 0000 7fcd none
R 0026 3 0000 127c none
R 0028 3 0000 5672 none
R 002c 3 0000 9abc none
W 0034 3 4321 0000 none
R 0034 3 0000 4321 none
R 0434 3 0000 6b6a 0030
R 0034 3 0000 4321 none

// ==== compile.f ====
+incdir+.
lc3b_types.sv
sel_bytes.sv
cache_datapath.sv
cache_control.sv
lc3b_cache.sv
tb_lc3b_cache.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f --top-module tb_lc3b_cache -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
